/* vlog.f */
src/bus_ctrl_pkg.sv
src/setting_reg.sv
src/sfp_pin_monitor.sv
src/control_regs.sv
src/fifo_fault_latch.sv
src/readback_mux.sv
src/bus_ctrl_top.sv
test/tb_bus_ctrl.sv

/* Makefile */
TOOL      = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only -Wall --timing
TOP       = tb_bus_ctrl
RTL_TOP   = bus_ctrl_top
FILELIST  = vlog.f
BUILD_DIR = obj_dir
SOURCES   = $(shell cat $(FILELIST))

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

/* test/tb_bus_ctrl.sv */
/*
 * Directed testbench for the housekeeping control and status core
 */
`timescale 1ns/1ps

module tb_bus_ctrl;

   localparam int WAIT_CYCLES = 50;

   logic                      clk;
   logic                      reset;
   bus_ctrl_pkg::set_bus_t    set_bus;
   bus_ctrl_pkg::rb_req_t     rb_req;
   logic [31:0]               rb_data;
   logic [7:0]                leds;
   bus_ctrl_pkg::sw_rst_t     sw_rst;
   bus_ctrl_pkg::clock_ctrl_t clock_ctrl;
   bus_ctrl_pkg::sfp_rs_t     sfp0_rs;
   bus_ctrl_pkg::sfp_rs_t     sfp1_rs;
   bus_ctrl_pkg::sfp_pins_t   sfp0_pins;
   bus_ctrl_pkg::sfp_pins_t   sfp1_pins;
   logic [4:0]                clock_status;
   bus_ctrl_pkg::fifo_flags_t fifo_flags;
   logic [31:0]               lfsr_state;
   // Expected control outputs as zero-extended words
   logic [31:0]               exp_leds;
   logic [31:0]               exp_sw_rst;
   logic [31:0]               exp_clock_ctrl;
   logic [31:0]               exp_sfp0_rs;
   logic [31:0]               exp_sfp1_rs;

   bus_ctrl_top bus_ctrl_top_i (
      .clk(clk), .reset(reset), .i_set(set_bus), .i_rb(rb_req),
      .o_rb_data(rb_data), .o_leds(leds), .o_sw_rst(sw_rst),
      .o_clock_ctrl(clock_ctrl), .o_sfp0_rs(sfp0_rs), .o_sfp1_rs(sfp1_rs),
      .i_sfp0_pins(sfp0_pins), .i_sfp1_pins(sfp1_pins),
      .i_clock_status(clock_status), .i_fifo_flags(fifo_flags)
   );

   // 20 ns period
   always #10 clk = ~clk;

   // Galois LFSR stepped once per bit taken
   function automatic logic [31:0] random_bits(input int n);
      logic [31:0] value;
      int          i;
      value = '0;
      for (i = 0; i < n; i++) begin
         value = {value[30:0], lfsr_state[0]};
         if (lfsr_state[0])
            lfsr_state = (lfsr_state >> 1) ^ 32'h8020_0003;
         else
            lfsr_state = lfsr_state >> 1;
      end
      return value;
   endfunction

   task automatic expect_equal(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
      assert (got === exp)
      else begin
         $display("error %s: got 0x%h, expected 0x%h", name, got, exp);
         $display("tests failed");
         $fatal(1, "value mismatch");
      end
   endtask

   task automatic check_controls();
      expect_equal("o_leds", {24'h0, leds}, exp_leds);
      expect_equal("o_sw_rst", {28'h0, sw_rst}, exp_sw_rst);
      expect_equal("o_clock_ctrl", {25'h0, clock_ctrl}, exp_clock_ctrl);
      expect_equal("o_sfp0_rs", {30'h0, sfp0_rs}, exp_sfp0_rs);
      expect_equal("o_sfp1_rs", {30'h0, sfp1_rs}, exp_sfp1_rs);
   endtask

   // --------------------
   // Bus access on the falling edge
   // --------------------
   task automatic set_write(input logic [7:0] addr, input logic [31:0] data);
      set_bus.stb  = 1'b1;
      set_bus.addr = addr;
      set_bus.data = data;
      @(negedge clk);
      set_bus.stb = 1'b0;
   endtask

   // Combinational readback sampled mid low phase
   task automatic rb_read(input logic [7:0] addr, input logic stb, output logic [31:0] data);
      rb_req.rd_stb = stb;
      rb_req.addr   = addr;
      #5;
      data = rb_data;
      @(negedge clk);
      rb_req.rd_stb = 1'b0;
   endtask

   task automatic wait_for_bit(input logic [7:0] addr, input int idx, input logic value);
      logic [31:0] word;
      int          count;
      count = 0;
      rb_read(addr, 1'b0, word);
      while (word[idx] !== value) begin
         if (count >= WAIT_CYCLES) begin
            $display("timeout waiting for bit %0d at readback address 0x%h", idx, addr);
            $display("tests failed");
            $fatal(1, "wait timed out");
         end else begin
            count++;
            rb_read(addr, 1'b0, word);
         end
      end
   endtask

   // --------------------
   // Directed tests
   // --------------------
   task automatic verify_reset_state();
      logic [31:0] word;
      check_controls();
      // Major in the upper half
      rb_read(bus_ctrl_pkg::RB_COMPAT_NUM, 1'b0, word);
      expect_equal("o_rb_data compat", word, 32'h0004_0000);
      rb_read(8'h77, 1'b0, word);
      expect_equal("o_rb_data unmapped", word, 32'h0);
   endtask

   task automatic control_write_sweep();
      logic [31:0] d;
      d = random_bits(32);
      set_write(bus_ctrl_pkg::SR_LEDS, d);
      exp_leds = {24'h0, d[7:0]};
      check_controls();
      d = random_bits(32);
      set_write(bus_ctrl_pkg::SR_SW_RST, d);
      exp_sw_rst = {28'h0, d[3:0]};
      check_controls();
      d = random_bits(32);
      set_write(bus_ctrl_pkg::SR_CLOCK_CTRL, d);
      exp_clock_ctrl = {25'h0, d[6:0]};
      check_controls();
      d = random_bits(32);
      set_write(bus_ctrl_pkg::SR_SFPP_CTRL0, d);
      exp_sfp0_rs = {30'h0, d[1:0]};
      check_controls();
      d = random_bits(32);
      set_write(bus_ctrl_pkg::SR_SFPP_CTRL1, d);
      exp_sfp1_rs = {30'h0, d[1:0]};
      check_controls();
      // Nothing lives here
      d = random_bits(32);
      set_write(8'h33, d);
      check_controls();
   endtask

   // Wait is on bit 0 so the pins need rx_los set
   task automatic sfp_change_and_clear(input int port, input logic [2:0] pins);
      logic [7:0]  addr;
      logic [7:0]  other_addr;
      logic [31:0] other_exp;
      logic [31:0] word;
      if (port == 0) begin
         addr       = bus_ctrl_pkg::RB_SFPP_STATUS0;
         other_addr = bus_ctrl_pkg::RB_SFPP_STATUS1;
         other_exp  = {29'h0, sfp1_pins};
         sfp0_pins  = pins;
      end else begin
         addr       = bus_ctrl_pkg::RB_SFPP_STATUS1;
         other_addr = bus_ctrl_pkg::RB_SFPP_STATUS0;
         other_exp  = {29'h0, sfp0_pins};
         sfp1_pins  = pins;
      end
      wait_for_bit(addr, 0, 1'b1);
      // Old levels were zero so the changed bits equal the pins
      rb_read(addr, 1'b0, word);
      expect_equal("o_rb_data sfp status", word, {26'h0, pins, pins});
      rb_read(other_addr, 1'b0, word);
      expect_equal("o_rb_data other sfp status", word, other_exp);
      // Strobed read returns the word, then clears change bits
      rb_read(addr, 1'b1, word);
      expect_equal("o_rb_data sfp status", word, {26'h0, pins, pins});
      rb_read(addr, 1'b0, word);
      expect_equal("o_rb_data sfp cleared", word, {29'h0, pins});
   endtask

   task automatic fifo_fault_capture();
      logic [31:0] tmp;
      logic [31:0] word;
      logic [31:0] exp;
      int          idx;
      tmp = random_bits(2);
      idx = int'(tmp[1:0]);
      exp = 32'h1 << idx;
      // One-cycle active-low pulse
      fifo_flags      = 4'hF;
      fifo_flags[idx] = 1'b0;
      @(negedge clk);
      fifo_flags = 4'hF;
      rb_read(bus_ctrl_pkg::RB_FIFOFLAGS, 1'b0, word);
      expect_equal("o_rb_data fifo faults", word, exp);
      repeat (3) @(negedge clk);
      rb_read(bus_ctrl_pkg::RB_FIFOFLAGS, 1'b0, word);
      expect_equal("o_rb_data fifo faults held", word, exp);
      tmp = random_bits(32);
      set_write(bus_ctrl_pkg::SR_FIFOFLAGS, tmp);
      wait_for_bit(bus_ctrl_pkg::RB_FIFOFLAGS, idx, 1'b0);
      rb_read(bus_ctrl_pkg::RB_FIFOFLAGS, 1'b0, word);
      expect_equal("o_rb_data fifo faults cleared", word, 32'h0);
   endtask

   task automatic counter_and_clock_readback();
      logic [31:0] first;
      logic [31:0] second;
      logic [31:0] tmp;
      int          k;
      tmp = random_bits(4);
      k   = int'(tmp[3:0]) + 2;
      // Each read takes one cycle
      rb_read(bus_ctrl_pkg::RB_COUNTER, 1'b0, first);
      repeat (k - 1) @(negedge clk);
      rb_read(bus_ctrl_pkg::RB_COUNTER, 1'b0, second);
      expect_equal("o_rb_data counter delta", second - first, 32'(k));
      tmp          = random_bits(5);
      clock_status = tmp[4:0];
      rb_read(bus_ctrl_pkg::RB_CLK_STATUS, 1'b0, first);
      expect_equal("o_rb_data clock status", first, {27'h0, tmp[4:0]});
   endtask

   initial begin
      clk            = 1'b0;
      reset          = 1'b1;
      set_bus        = '0;
      rb_req         = '0;
      sfp0_pins      = '0;
      sfp1_pins      = '0;
      clock_status   = '0;
      fifo_flags     = 4'hF;
      lfsr_state     = 32'd19;
      exp_leds       = 32'h0;
      exp_sw_rst     = 32'h0;
      exp_clock_ctrl = 32'h40;
      exp_sfp0_rs    = 32'h0;
      exp_sfp1_rs    = 32'h0;
      repeat (5) @(negedge clk);
      reset = 1'b0;
      verify_reset_state();
      control_write_sweep();
      sfp_change_and_clear(0, 3'b101);
      sfp_change_and_clear(1, 3'b011);
      fifo_fault_capture();
      counter_and_clock_readback();
      $display("all tests passed");
      $finish;
   end

endmodule

/* src/bus_ctrl_top.sv */
/*
 * Housekeeping control and status core: settings bus in,
 * readback bus out, SFP+ and FIFO monitoring in between
 */
`timescale 1ns/1ps

module bus_ctrl_top (
   input  logic                                 clk,
   input  logic                                 reset,
   input  bus_ctrl_pkg::set_bus_t                i_set,
   input  bus_ctrl_pkg::rb_req_t                 i_rb,
   output logic [bus_ctrl_pkg::DATA_WIDTH-1:0]  o_rb_data,
   output logic [7:0]                           o_leds,
   output bus_ctrl_pkg::sw_rst_t                 o_sw_rst,
   output bus_ctrl_pkg::clock_ctrl_t             o_clock_ctrl,
   output bus_ctrl_pkg::sfp_rs_t                 o_sfp0_rs,
   output bus_ctrl_pkg::sfp_rs_t                 o_sfp1_rs,
   input  bus_ctrl_pkg::sfp_pins_t               i_sfp0_pins,
   input  bus_ctrl_pkg::sfp_pins_t               i_sfp1_pins,
   input  logic [4:0]                           i_clock_status,
   input  bus_ctrl_pkg::fifo_flags_t             i_fifo_flags
);

   bus_ctrl_pkg::sfp_status_t sfp0_status;
   bus_ctrl_pkg::sfp_status_t sfp1_status;
   bus_ctrl_pkg::fifo_flags_t faults;

   // --------------------
   // Input side
   // --------------------
   sfp_pin_monitor #(.RB_ADDR(bus_ctrl_pkg::RB_SFPP_STATUS0)) sfp0_mon_i (
      .clk(clk), .reset(reset),
      .i_pins(i_sfp0_pins), .i_rb(i_rb), .o_status(sfp0_status)
   );

   sfp_pin_monitor #(.RB_ADDR(bus_ctrl_pkg::RB_SFPP_STATUS1)) sfp1_mon_i (
      .clk(clk), .reset(reset),
      .i_pins(i_sfp1_pins), .i_rb(i_rb), .o_status(sfp1_status)
   );

   // --------------------
   // Processing
   // --------------------
   control_regs control_regs_i (
      .clk(clk), .reset(reset), .i_set(i_set),
      .o_leds(o_leds), .o_sw_rst(o_sw_rst), .o_clock_ctrl(o_clock_ctrl),
      .o_sfp0_rs(o_sfp0_rs), .o_sfp1_rs(o_sfp1_rs)
   );

   fifo_fault_latch fifo_fault_latch_i (
      .clk(clk), .reset(reset), .i_set(i_set),
      .i_fifo_flags(i_fifo_flags), .o_faults(faults)
   );

   // --------------------
   // Output side
   // --------------------
   readback_mux readback_mux_i (
      .clk(clk), .reset(reset), .i_rb(i_rb),
      .i_clock_status(i_clock_status),
      .i_sfp0_status(sfp0_status), .i_sfp1_status(sfp1_status),
      .i_faults(faults), .o_rb_data(o_rb_data)
   );

endmodule

/* src/readback_mux.sv */
/*
 * Readback side: free-running cycle counter and the
 * address-decoded status word
 */
`timescale 1ns/1ps

module readback_mux (
   input  logic                                 clk,
   input  logic                                 reset,
   input  bus_ctrl_pkg::rb_req_t                 i_rb,
   input  logic [4:0]                           i_clock_status,
   input  bus_ctrl_pkg::sfp_status_t             i_sfp0_status,
   input  bus_ctrl_pkg::sfp_status_t             i_sfp1_status,
   input  bus_ctrl_pkg::fifo_flags_t             i_faults,
   output logic [bus_ctrl_pkg::DATA_WIDTH-1:0]  o_rb_data
);

   localparam int SFP_W  = $bits(bus_ctrl_pkg::sfp_status_t);
   localparam int FAIL_W = $bits(bus_ctrl_pkg::fifo_flags_t);

   logic [bus_ctrl_pkg::DATA_WIDTH-1:0] counter_q;

   // Cycle counter, wraps silently
   always_ff @(posedge clk) begin
      if (reset)
         counter_q <= '0;
      else
         counter_q <= counter_q + 1'b1;
   end

   // --------------------
   // Address decode
   // --------------------
   always_comb begin
      // Unmapped and short words read as zero
      o_rb_data = '0;
      case (i_rb.addr)
         bus_ctrl_pkg::RB_COUNTER:      o_rb_data = counter_q;
         bus_ctrl_pkg::RB_CLK_STATUS:   o_rb_data[4:0] = i_clock_status;
         bus_ctrl_pkg::RB_COMPAT_NUM:
            o_rb_data = {bus_ctrl_pkg::COMPAT_MAJOR, bus_ctrl_pkg::COMPAT_MINOR};
         bus_ctrl_pkg::RB_SFPP_STATUS0: o_rb_data[SFP_W-1:0] = i_sfp0_status;
         bus_ctrl_pkg::RB_SFPP_STATUS1: o_rb_data[SFP_W-1:0] = i_sfp1_status;
         bus_ctrl_pkg::RB_FIFOFLAGS:    o_rb_data[FAIL_W-1:0] = i_faults;
         default:                       o_rb_data = '0;
      endcase
   end

endmodule

/* src/fifo_fault_latch.sv */
/*
 * FIFO fault capture: active-low flags held until cleared
 * by a settings write
 */
`timescale 1ns/1ps

module fifo_fault_latch (
   input  logic                     clk,
   input  logic                     reset,
   input  bus_ctrl_pkg::set_bus_t    i_set,
   input  bus_ctrl_pkg::fifo_flags_t i_fifo_flags,
   output bus_ctrl_pkg::fifo_flags_t o_faults
);

   logic clear;

   // Any write to this address clears, data is ignored
   setting_reg #(
      .ADDR        (bus_ctrl_pkg::SR_FIFOFLAGS),
      .T           (logic),
      .RESET_VALUE (1'b0)
   ) clear_reg_i (
      .clk(clk), .reset(reset), .i_set(i_set),
      .o_value(), .o_changed(clear)
   );

   // Sticky so one-cycle faults survive until read
   always_ff @(posedge clk) begin
      if (reset || clear) begin
         o_faults <= '0;
      end else begin
         // Flags are active low
         o_faults <= o_faults | ~i_fifo_flags;
      end
   end

endmodule

/* src/control_regs.sv */
/*
 * Board control register bank: LEDs, software resets,
 * clock control and SFP+ rate selects
 */
`timescale 1ns/1ps

module control_regs (
   input  logic                     clk,
   input  logic                     reset,
   input  bus_ctrl_pkg::set_bus_t    i_set,
   output logic [7:0]               o_leds,
   output bus_ctrl_pkg::sw_rst_t     o_sw_rst,
   output bus_ctrl_pkg::clock_ctrl_t o_clock_ctrl,
   output bus_ctrl_pkg::sfp_rs_t     o_sfp0_rs,
   output bus_ctrl_pkg::sfp_rs_t     o_sfp1_rs
);

   // Front panel LED pattern
   setting_reg #(
      .ADDR        (bus_ctrl_pkg::SR_LEDS),
      .T           (logic [7:0]),
      .RESET_VALUE (8'h00)
   ) leds_reg_i (
      .clk(clk), .reset(reset), .i_set(i_set),
      .o_value(o_leds), .o_changed()
   );

   // PHY, radio domain and radio PLL resets
   setting_reg #(
      .ADDR        (bus_ctrl_pkg::SR_SW_RST),
      .T           (bus_ctrl_pkg::sw_rst_t),
      .RESET_VALUE ('0)
   ) sw_rst_reg_i (
      .clk(clk), .reset(reset), .i_set(i_set),
      .o_value(o_sw_rst), .o_changed()
   );

   // Comes up with the GPSDO enabled
   setting_reg #(
      .ADDR        (bus_ctrl_pkg::SR_CLOCK_CTRL),
      .T           (bus_ctrl_pkg::clock_ctrl_t),
      .RESET_VALUE (bus_ctrl_pkg::CLOCK_CTRL_RESET)
   ) clock_ctrl_reg_i (
      .clk(clk), .reset(reset), .i_set(i_set),
      .o_value(o_clock_ctrl), .o_changed()
   );

   // --------------------
   // SFP+ rate selects
   // --------------------
   setting_reg #(
      .ADDR        (bus_ctrl_pkg::SR_SFPP_CTRL0),
      .T           (bus_ctrl_pkg::sfp_rs_t),
      .RESET_VALUE ('0)
   ) sfp0_rs_reg_i (
      .clk(clk), .reset(reset), .i_set(i_set),
      .o_value(o_sfp0_rs), .o_changed()
   );

   setting_reg #(
      .ADDR        (bus_ctrl_pkg::SR_SFPP_CTRL1),
      .T           (bus_ctrl_pkg::sfp_rs_t),
      .RESET_VALUE ('0)
   ) sfp1_rs_reg_i (
      .clk(clk), .reset(reset), .i_set(i_set),
      .o_value(o_sfp1_rs), .o_changed()
   );

endmodule

/* src/sfp_pin_monitor.sv */
/*
 * SFP+ status pin monitor: two-stage pin sync, with sticky
 * change bits cleared by a read of this cage's status word
 */
`timescale 1ns/1ps

module sfp_pin_monitor #(
   parameter logic [bus_ctrl_pkg::RB_AWIDTH-1:0] RB_ADDR = bus_ctrl_pkg::RB_SFPP_STATUS0
) (
   input  logic                     clk,
   input  logic                     reset,
   input  bus_ctrl_pkg::sfp_pins_t   i_pins,
   input  bus_ctrl_pkg::rb_req_t     i_rb,
   output bus_ctrl_pkg::sfp_status_t o_status
);

   bus_ctrl_pkg::sfp_pins_t sync1_q;
   bus_ctrl_pkg::sfp_pins_t sync2_q;
   bus_ctrl_pkg::sfp_pins_t chg_q;
   bus_ctrl_pkg::sfp_pins_t diff;
   logic                    rd_hit;

   // --------------------
   // Pin synchroniser
   // --------------------
   always_ff @(posedge clk) begin
      sync1_q <= i_pins;
      sync2_q <= sync1_q;
   end

   // Stages disagree means a new level is about to land
   assign diff = sync1_q ^ sync2_q;

   // Real read of our own status word
   assign rd_hit = i_rb.rd_stb && (i_rb.addr == RB_ADDR);

   // --------------------
   // Sticky change bits
   // --------------------
   always_ff @(posedge clk) begin
      if (reset || rd_hit) begin
         // Clear beats a change in the same cycle
         chg_q <= '0;
      end else begin
         chg_q <= chg_q | diff;
      end
   end

   assign o_status.changed = chg_q;
   assign o_status.level   = sync2_q;

endmodule

/* src/setting_reg.sv */
/*
 * Settings register: loads its payload on an address match
 * and flags the update with a one-cycle change pulse
 */
`timescale 1ns/1ps

module setting_reg #(
   parameter logic [bus_ctrl_pkg::SR_AWIDTH-1:0] ADDR = '0,
   parameter type T = logic [7:0],
   parameter T RESET_VALUE = '0
) (
   input  logic                  clk,
   input  logic                  reset,
   input  bus_ctrl_pkg::set_bus_t i_set,
   output T                      o_value,
   output logic                  o_changed
);

   logic hit;

   // Write strobe aimed at this register
   assign hit = i_set.stb && (i_set.addr == ADDR);

   always_ff @(posedge clk) begin
      if (reset) begin
         o_value   <= RESET_VALUE;
         o_changed <= 1'b0;
      end else begin
         // Payload is the low bits of the data word
         if (hit)
            o_value <= T'(i_set.data[$bits(T)-1:0]);
         // High for the single cycle after the write
         o_changed <= hit;
      end
   end

endmodule

/* src/bus_ctrl_pkg.sv */
/*
 * Housekeeping bus definitions: widths, register map, compat number
 * and the packed types shared by the control and status blocks
 */
package bus_ctrl_pkg;

   // --------------------
   // Bus widths
   // --------------------
   localparam int SR_AWIDTH  = 8;
   localparam int RB_AWIDTH  = 8;
   localparam int DATA_WIDTH = 32;

   // Settings register map
   localparam logic [SR_AWIDTH-1:0] SR_LEDS       = 8'd0;
   localparam logic [SR_AWIDTH-1:0] SR_SW_RST     = 8'd1;
   localparam logic [SR_AWIDTH-1:0] SR_CLOCK_CTRL = 8'd2;
   localparam logic [SR_AWIDTH-1:0] SR_SFPP_CTRL0 = 8'd8;
   localparam logic [SR_AWIDTH-1:0] SR_SFPP_CTRL1 = 8'd9;
   localparam logic [SR_AWIDTH-1:0] SR_FIFOFLAGS  = 8'd10;

   // Readback map, same 8-bit space
   localparam logic [RB_AWIDTH-1:0] RB_COUNTER      = 8'd0;
   localparam logic [RB_AWIDTH-1:0] RB_CLK_STATUS   = 8'd3;
   localparam logic [RB_AWIDTH-1:0] RB_COMPAT_NUM   = 8'd6;
   localparam logic [RB_AWIDTH-1:0] RB_SFPP_STATUS0 = 8'd8;
   localparam logic [RB_AWIDTH-1:0] RB_SFPP_STATUS1 = 8'd9;
   localparam logic [RB_AWIDTH-1:0] RB_FIFOFLAGS    = 8'd10;

   // Compat number, major goes in the upper half
   localparam logic [15:0] COMPAT_MAJOR = 16'h0004;
   localparam logic [15:0] COMPAT_MINOR = 16'h0000;

   // Bit 6 enables the GPS-disciplined oscillator
   localparam logic [6:0] CLOCK_CTRL_RESET = 7'b100_0000;

   // --------------------
   // Bus transfers
   // --------------------
   typedef struct packed {
      logic                  stb;
      logic [SR_AWIDTH-1:0]  addr;
      logic [DATA_WIDTH-1:0] data;
   } set_bus_t;

   typedef struct packed {
      logic                 rd_stb;
      logic [RB_AWIDTH-1:0] addr;
   } rb_req_t;

   // --------------------
   // SFP+ cage signals
   // --------------------
   typedef struct packed {
      logic mod_abs;
      logic tx_fault;
      logic rx_los;
   } sfp_pins_t;

   // Sticky change flags sit above the synced levels
   typedef struct packed {
      sfp_pins_t changed;
      sfp_pins_t level;
   } sfp_status_t;

   // High means pull the rate-select pin low
   typedef struct packed {
      logic rs1;
      logic rs0;
   } sfp_rs_t;

   typedef logic [6:0] clock_ctrl_t;

   typedef struct packed {
      logic unused;
      logic radio_pll;
      logic radio_domain;
      logic phy;
   } sw_rst_t;

   typedef logic [3:0] fifo_flags_t;

endpackage
